//--- source/mem_pkg.sv
// Memory stage package with widths, cache geometry, funct3 codes and shared types
package mem_pkg;

    // Cache and memory geometry
    localparam int LINE_BITS      = 128;
    localparam int CACHE_LINES    = 16;
    localparam int SB_DEPTH       = 4;
    localparam int MEM_LATENCY    = 4;
    localparam int MEM_WORDS      = 1024;
    localparam int WORDS_PER_LINE = LINE_BITS / 32;
    localparam int WSEL_BITS      = $clog2(WORDS_PER_LINE);
    localparam int OFFSET_BITS    = $clog2(LINE_BITS / 8);
    localparam int INDEX_BITS     = $clog2(CACHE_LINES);
    localparam int TAG_BITS       = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int MEM_WIDX_BITS  = $clog2(MEM_WORDS);
    localparam int SB_PTR_BITS    = $clog2(SB_DEPTH);
    localparam int LAT_BITS       = $clog2(MEM_LATENCY + 1);

    typedef logic [31:0]          addr_t;
    typedef logic [31:0]          word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [3:0]           rob_idx_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // RISC-V load and store size codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    // Request from the execute stage
    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        funct3_t  funct3;
        logic     read_en;
        logic     write_en;
        reg_idx_t rd;
        logic     mem_to_reg;
        logic     reg_write;
        rob_idx_t rob_idx;
    } mem_req_t;

    // Result toward writeback and the ROB
    typedef struct packed {
        addr_t    alu_out;
        word_t    read_data;
        reg_idx_t rd;
        logic     mem_to_reg;
        logic     reg_write;
        logic     complete;
        rob_idx_t complete_idx;
    } mem_resp_t;

    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        funct3_t funct3;
    } sb_entry_t;

    // Line transfer to the backing memory
    typedef struct packed {
        logic  mem_read_en;
        logic  mem_write_en;
        addr_t mem_addr;
        line_t mem_wdata;
    } line_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        REFILL_DONE
    } cache_state_t;

endpackage

//--- source/data_cache.sv
// Data cache, direct mapped and write back, with refill FSM and sub-word stores
`timescale 1ns/1ps

module data_cache import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  addr_t     addr,
    input  word_t     wdata,
    input  funct3_t   funct3,
    input  logic      read_en,
    input  logic      write_en,
    input  line_t     mem_rdata,
    input  logic      mem_ready,
    output word_t     rdata,
    output logic      busy,
    output logic      done,
    output line_req_t line_req
);

    cache_state_t state_q;
    cache_state_t state_d;

    // Line storage and per-line status
    line_t                  line_q [CACHE_LINES];
    tag_t                   tag_q  [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    logic [CACHE_LINES-1:0] dirty_q;

    tag_t                 tag;
    index_t               idx;
    logic [WSEL_BITS-1:0] wsel;
    logic                 hit;
    logic                 access;
    logic                 serve;
    line_t                cur_line;
    line_t                store_line;
    word_t                cur_word;
    word_t                shifted;
    word_t                store_data;
    word_t                merged;
    logic [3:0]           lane_mask;

    // Address split
    assign tag  = addr[31 -: TAG_BITS];
    assign idx  = addr[OFFSET_BITS +: INDEX_BITS];
    assign wsel = addr[2 +: WSEL_BITS];

    assign cur_line = line_q[idx];
    assign cur_word = cur_line[wsel*32 +: 32];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign access   = read_en || write_en;
    // Accesses are served in IDLE and right after a refill
    assign serve    = (state_q == IDLE) || (state_q == REFILL_DONE);
    assign busy     = !serve || (access && !hit);
    assign done     = serve && access && hit;

    // Load path, align then extend
    assign shifted = cur_word >> {addr[1:0], 3'b000};
    always_comb begin
        case (funct3)
            F3_LB:   rdata = {{24{shifted[7]}}, shifted[7:0]};
            F3_LH:   rdata = {{16{shifted[15]}}, shifted[15:0]};
            F3_LBU:  rdata = {24'h0, shifted[7:0]};
            F3_LHU:  rdata = {16'h0, shifted[15:0]};
            F3_LW:   rdata = cur_word;
            default: rdata = cur_word;
        endcase
    end

    // Store path, byte lanes replicated then masked
    always_comb begin
        case (funct3)
            F3_SB: begin
                lane_mask  = 4'b0001 << addr[1:0];
                store_data = {4{wdata[7:0]}};
            end
            F3_SH: begin
                lane_mask  = 4'b0011 << {addr[1], 1'b0};
                store_data = {2{wdata[15:0]}};
            end
            F3_SW: begin
                lane_mask  = 4'b1111;
                store_data = wdata;
            end
            default: begin
                lane_mask  = 4'b1111;
                store_data = wdata;
            end
        endcase
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = lane_mask[b] ? store_data[b*8 +: 8] : cur_word[b*8 +: 8];
        end
        store_line = cur_line;
        store_line[wsel*32 +: 32] = merged;
    end

    // Miss handling FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, REFILL_DONE: begin
                if (access && !hit) begin
                    // Dirty victim goes out before the refill
                    state_d = (valid_q[idx] && dirty_q[idx]) ? WRITEBACK : REFILL;
                end else begin
                    state_d = IDLE;
                end
            end
            WRITEBACK: begin
                if (mem_ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ready) begin
                    state_d = REFILL_DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Memory request, held steady by the state until ready
    always_comb begin
        line_req = '0;
        case (state_q)
            WRITEBACK: begin
                line_req.mem_write_en = 1'b1;
                line_req.mem_addr     = {tag_q[idx], idx, {OFFSET_BITS{1'b0}}};
                line_req.mem_wdata    = cur_line;
            end
            REFILL: begin
                line_req.mem_read_en = 1'b1;
                line_req.mem_addr    = {tag, idx, {OFFSET_BITS{1'b0}}};
            end
            default: line_req = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == REFILL && mem_ready) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end else if (done && write_en) begin
                // Write allocate, line marked dirty
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REFILL && mem_ready) begin
            line_q[idx] <= mem_rdata;
            tag_q[idx]  <= tag;
        end else if (done && write_en) begin
            line_q[idx] <= store_line;
        end
    end

endmodule

//--- source/store_buffer.sv
// Store buffer, FIFO of pending stores with word address match for loads
`timescale 1ns/1ps

module store_buffer import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  sb_entry_t push_entry,
    input  logic      pop,
    input  addr_t     lookup_addr,
    output sb_entry_t head,
    output logic      empty,
    output logic      full,
    output logic      match
);

    sb_entry_t              entry_q [SB_DEPTH];
    logic [SB_DEPTH-1:0]    valid_q;
    logic [SB_PTR_BITS-1:0] wr_ptr_q;
    logic [SB_PTR_BITS-1:0] rd_ptr_q;
    logic [SB_PTR_BITS:0]   count_q;
    logic                   do_push;
    logic                   do_pop;

    assign empty   = (count_q == '0);
    assign full    = (count_q == (SB_PTR_BITS+1)'(SB_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = entry_q[rd_ptr_q];

    // Word granular compare over live entries
    always_comb begin
        match = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid_q[i] && (entry_q[i].addr[31:2] == lookup_addr[31:2])) begin
                match = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q          <= wr_ptr_q + 1'b1;
                valid_q[wr_ptr_q] <= 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q          <= rd_ptr_q + 1'b1;
                valid_q[rd_ptr_q] <= 1'b0;
            end
            // Count moves only when one side acts alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (do_push) begin
            entry_q[wr_ptr_q] <= push_entry;
        end
    end

endmodule

//--- source/stage_cache.sv
// Memory stage, shares the cache port between loads and store buffer drains
`timescale 1ns/1ps

module stage_cache import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_req_t  req,
    input  line_t     mem_rdata,
    input  logic      mem_ready,
    output mem_resp_t resp,
    output logic      stall,
    output line_req_t line_req
);

    sb_entry_t sb_head;
    sb_entry_t cache_acc;
    logic      sb_empty;
    logic      sb_full;
    logic      sb_match;
    logic      sb_push;
    logic      sb_pop;
    logic      is_load;
    logic      is_store;
    logic      sel_load;
    logic      drain_busy_q;
    word_t     cache_rdata;
    logic      cache_busy;
    logic      cache_done;

    assign is_load  = req.read_en;
    assign is_store = req.write_en && !req.read_en;

    // Load wins unless a matching store is pending or a drain owns the miss FSM
    assign sel_load  = is_load && !sb_match && !drain_busy_q;
    assign cache_acc = sel_load ? sb_entry_t'{addr: req.addr, wdata: req.wdata,
                                              funct3: req.funct3}
                                : sb_head;

    // Stall sources
    assign stall   = (is_load && !(sel_load && cache_done)) || (is_store && sb_full);
    assign sb_push = is_store && !sb_full;
    assign sb_pop  = !sel_load && cache_done;

    // Drain keeps the port until its miss is finished
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_busy_q <= 1'b0;
        end else if (cache_done) begin
            drain_busy_q <= 1'b0;
        end else if (!sel_load && !sb_empty && cache_busy) begin
            drain_busy_q <= 1'b1;
        end
    end

    data_cache u_data_cache (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (cache_acc.addr),
        .wdata    (cache_acc.wdata),
        .funct3   (cache_acc.funct3),
        .read_en  (sel_load),
        .write_en (!sel_load && !sb_empty),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .rdata    (cache_rdata),
        .busy     (cache_busy),
        .done     (cache_done),
        .line_req (line_req)
    );

    store_buffer u_store_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (sb_push),
        .push_entry (sb_entry_t'{addr: req.addr, wdata: req.wdata,
                                 funct3: req.funct3}),
        .pop        (sb_pop),
        .lookup_addr(req.addr),
        .head       (sb_head),
        .empty      (sb_empty),
        .full       (sb_full),
        .match      (sb_match)
    );

    // Pass-through control plus completion toward the ROB
    assign resp.alu_out      = req.addr;
    assign resp.read_data    = cache_rdata;
    assign resp.rd           = req.rd;
    assign resp.mem_to_reg   = req.mem_to_reg;
    assign resp.reg_write    = req.reg_write;
    // Load served by the cache, or store taken by the buffer
    assign resp.complete     = (sel_load && cache_done) || sb_push;
    assign resp.complete_idx = req.rob_idx;

endmodule

//--- source/main_memory.sv
// Backing memory, line wide with fixed latency and a known fill pattern
`timescale 1ns/1ps

module main_memory import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  line_req_t line_req,
    output line_t     mem_rdata,
    output logic      mem_ready
);

    word_t                      mem_q [MEM_WORDS];
    logic [LAT_BITS-1:0]        cnt_q;
    logic [MEM_WIDX_BITS-WSEL_BITS-1:0] line_idx;

    // Fill pattern seen by cold reads
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = word_t'(i) * 32'h0101_0101 ^ 32'hA5A5_0000;
        end
    end

    // Upper address bits beyond the array alias
    assign line_idx  = line_req.mem_addr[OFFSET_BITS +: MEM_WIDX_BITS-WSEL_BITS];
    assign mem_ready = (cnt_q == LAT_BITS'(MEM_LATENCY));

    always_comb begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            mem_rdata[w*32 +: 32] = mem_q[{line_idx, WSEL_BITS'(w)}];
        end
    end

    // Latency counter, starts on the first cycle an enable shows up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (cnt_q == '0) begin
            if (line_req.mem_read_en || line_req.mem_write_en) begin
                cnt_q <= LAT_BITS'(1);
            end
        end else if (mem_ready) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Write lands with the ready pulse
    always_ff @(posedge clk) begin
        if (mem_ready && line_req.mem_write_en) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_q[{line_idx, WSEL_BITS'(w)}] <= line_req.mem_wdata[w*32 +: 32];
            end
        end
    end

endmodule

//--- source/cache_subsystem.sv
// Cache subsystem top, memory stage joined to its backing memory
`timescale 1ns/1ps

module cache_subsystem import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_req_t  req,
    output mem_resp_t resp,
    output logic      stall
);

    // Line interface between stage and memory
    line_req_t line_req;
    line_t     mem_rdata;
    logic      mem_ready;

    stage_cache u_stage_cache (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .resp     (resp),
        .stall    (stall),
        .line_req (line_req)
    );

    main_memory u_main_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .line_req (line_req),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready)
    );

endmodule

//--- tb/cache_subsystem_properties.sv
// Handshake and memory interface assertions for the memory stage
`timescale 1ns/1ps

module cache_subsystem_properties import mem_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input mem_req_t  req,
    input mem_resp_t resp,
    input logic      stall,
    input line_req_t line_req,
    input logic      mem_ready
);

    // Pipeline holds its request while stalled
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(req))
        else $error("request changed while stall was high");

    a_ready_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> (line_req.mem_read_en || line_req.mem_write_en))
        else $error("mem_ready without a pending line request");

    // Line request stays up until the ready pulse
    a_line_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((line_req.mem_read_en || line_req.mem_write_en) && !mem_ready)
        |=> (line_req.mem_read_en || line_req.mem_write_en))
        else $error("line request dropped before mem_ready");

    a_no_complete_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(resp.complete && stall))
        else $error("complete raised while stall was high");

endmodule

bind stage_cache cache_subsystem_properties u_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .resp     (resp),
    .stall    (stall),
    .line_req (line_req),
    .mem_ready(mem_ready)
);

//--- tb/tb_cache_subsystem.sv
// Testbench for the cache subsystem, table driven against a reference memory model
`timescale 1ns/1ps

module tb_cache_subsystem import mem_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int NUM_OPS    = 29;
    // Worst case cycles per request, own miss plus a full buffer of drains
    localparam int OP_BOUND   = 2*MEM_LATENCY + 3 + SB_DEPTH*(2*MEM_LATENCY + 3);

    // Operation kinds
    localparam logic [1:0] K_LD  = 2'd0;
    localparam logic [1:0] K_ST  = 2'd1;
    localparam logic [1:0] K_RLD = 2'd2;  // address from the LCG
    localparam logic [1:0] K_RST = 2'd3;  // data from the LCG

    typedef struct packed {
        logic [1:0] kind;
        addr_t      addr;
        word_t      data;
        funct3_t    f3;
    } op_t;

    logic      clk;
    logic      rst_n;
    mem_req_t  req;
    mem_resp_t resp;
    logic      stall;

    word_t       ref_mem [MEM_WORDS];
    logic [31:0] lcg_state;
    string       cur_test;
    int          errors;
    int          test_errors;

    string test_name [NUM_TESTS] = '{"cold_loads", "store_load", "subword",
                                     "conflict_wb", "sb_burst"};
    int    test_len  [NUM_TESTS] = '{4, 4, 8, 4, 9};
    // Only the burst outruns the buffer depth
    logic  store_stall_exp [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    op_t ops [NUM_OPS] = '{
        '{K_RLD, 32'h0, 32'h0, F3_LW}, '{K_RLD, 32'h0, 32'h0, F3_LW},
        '{K_RLD, 32'h0, 32'h0, F3_LW}, '{K_RLD, 32'h0, 32'h0, F3_LW},
        '{K_RST, 32'h040, 32'h0, F3_SW}, '{K_LD, 32'h040, 32'h0, F3_LW},
        '{K_RST, 32'h044, 32'h0, F3_SW}, '{K_LD, 32'h044, 32'h0, F3_LW},
        // Byte and half stores, then every load width
        '{K_ST, 32'h081, 32'h0000_00F3, F3_SB}, '{K_ST, 32'h086, 32'h0000_8001, F3_SH},
        '{K_LD, 32'h081, 32'h0, F3_LB}, '{K_LD, 32'h081, 32'h0, F3_LBU},
        '{K_LD, 32'h086, 32'h0, F3_LH}, '{K_LD, 32'h086, 32'h0, F3_LHU},
        '{K_LD, 32'h080, 32'h0, F3_LW}, '{K_LD, 32'h084, 32'h0, F3_LW},
        // Same index 0, tags 1 and 9
        '{K_ST, 32'h100, 32'h1111_1111, F3_SW}, '{K_ST, 32'h900, 32'h2222_2222, F3_SW},
        '{K_LD, 32'h900, 32'h0, F3_LW}, '{K_LD, 32'h100, 32'h0, F3_LW},
        // More stores than buffer entries
        '{K_RST, 32'h200, 32'h0, F3_SW}, '{K_RST, 32'h210, 32'h0, F3_SW},
        '{K_RST, 32'h220, 32'h0, F3_SW}, '{K_RST, 32'h230, 32'h0, F3_SW},
        '{K_RST, 32'h240, 32'h0, F3_SW}, '{K_RST, 32'h250, 32'h0, F3_SW},
        '{K_LD, 32'h200, 32'h0, F3_LW}, '{K_LD, 32'h230, 32'h0, F3_LW},
        '{K_LD, 32'h250, 32'h0, F3_LW}
    };

    cache_subsystem u_cache_subsystem (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .resp (resp),
        .stall(stall)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Backing memory power-up pattern
    task automatic init_model();
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hA5A5_0000;
        end
    endtask

    task automatic model_store(input addr_t a, input word_t d, input funct3_t f3);
        word_t w;
        w = ref_mem[a[2 +: MEM_WIDX_BITS]];
        case (f3)
            F3_SB:   w[a[1:0]*8 +: 8] = d[7:0];
            F3_SH:   w[a[1]*16 +: 16] = d[15:0];
            default: w = d;
        endcase
        ref_mem[a[2 +: MEM_WIDX_BITS]] = w;
    endtask

    function automatic word_t model_load(input addr_t a, input funct3_t f3);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[a[2 +: MEM_WIDX_BITS]];
        b = w[a[1:0]*8 +: 8];
        h = w[a[1]*16 +: 16];
        case (f3)
            F3_LB:   return {{24{b[7]}}, b};
            F3_LBU:  return {24'h0, b};
            F3_LH:   return {{16{h[15]}}, h};
            F3_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_rob(input string what, input rob_idx_t exp, input rob_idx_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    // Watchdog sized from the op count
    initial begin
        #((NUM_OPS * OP_BOUND + 20) * CLK_PERIOD);
        $display("Timeout: the memory stage stopped accepting requests");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int       op_idx;
        int       clean;
        op_t      op;
        addr_t    a;
        word_t    d;
        mem_req_t sent;
        logic     store_stalled;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = '0;
        errors    = 0;
        clean     = 0;
        op_idx    = 0;
        lcg_state = 32'd42;
        init_model();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test      = test_name[t];
            test_errors   = 0;
            store_stalled = 1'b0;
            for (int k = 0; k < test_len[t]; k++) begin
                op = ops[op_idx];
                a  = op.addr;
                d  = op.data;
                if (op.kind == K_RLD) begin
                    lcg_state = lcg_next(lcg_state);
                    a = {20'h0, lcg_state[11:2], 2'b00};
                end
                if (op.kind == K_RST) begin
                    lcg_state = lcg_next(lcg_state);
                    d = lcg_state;
                end
                sent            = '0;
                sent.addr       = a;
                sent.wdata      = d;
                sent.funct3     = op.f3;
                sent.read_en    = (op.kind == K_LD) || (op.kind == K_RLD);
                sent.write_en   = !sent.read_en;
                sent.rd         = reg_idx_t'(op_idx + 1);
                sent.mem_to_reg = sent.read_en;
                sent.reg_write  = sent.read_en;
                sent.rob_idx    = rob_idx_t'(op_idx);
                req = sent;
                // Mid-cycle sampling, accepted at the next rising edge
                @(negedge clk);
                while (stall) begin
                    if (sent.write_en) begin
                        store_stalled = 1'b1;
                    end
                    @(negedge clk);
                end
                check_flag("complete", 1'b1, resp.complete);
                check_word("alu_out", a, resp.alu_out);
                check_reg("rd", sent.rd, resp.rd);
                check_flag("mem_to_reg", sent.mem_to_reg, resp.mem_to_reg);
                check_flag("reg_write", sent.reg_write, resp.reg_write);
                check_rob("complete_idx", sent.rob_idx, resp.complete_idx);
                if (sent.read_en) begin
                    check_word("read_data", model_load(a, op.f3), resp.read_data);
                end else begin
                    model_store(a, d, op.f3);
                end
                @(posedge clk);
                #1;
                op_idx++;
            end
            req.read_en  = 1'b0;
            req.write_en = 1'b0;
            check_flag("store_stall", store_stall_exp[t], store_stalled);
            $display("%-12s %0d ops, %0d errors", cur_test, test_len[t], test_errors);
            if (test_errors == 0) begin
                clean++;
            end
            errors += test_errors;
        end
        repeat (2) @(posedge clk);
        $display("Summary: %0d of %0d tests clean, %0d errors", clean, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/mem_pkg.sv
source/data_cache.sv
source/store_buffer.sv
source/stage_cache.sv
source/main_memory.sv
source/cache_subsystem.sv
tb/cache_subsystem_properties.sv
tb/tb_cache_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cache subsystem simulation with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_cache_subsystem -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Result: PASS"
else
    echo "Result: FAIL"
    exit 1
fi
